// File: logic/fpu_pkg.sv
// shared definitions of the bfloat16 FPU
// format widths, word types, opcodes, datapath structs and operand helpers
package fpu_pkg;

	////////////////////////////////////////////////////////////
	// format
	////////////////////////////////////////////////////////////

	localparam int FLOAT_DW   = 16;
	localparam int FLOAT_E_DW = 8;
	localparam int FLOAT_F_DW = 7;

	typedef logic [FLOAT_DW-1:0]   float_t;
	typedef logic [FLOAT_E_DW-1:0] exp_t;
	// one headroom bit for carries out of the exponent
	typedef logic [FLOAT_E_DW:0]   ext_exp_t;
	// hidden bit made explicit
	typedef logic [FLOAT_F_DW:0]   ext_frac_t;
	// hidden, fraction, guard, round, sticky
	typedef logic [FLOAT_F_DW+3:0] rnd_frac_t;

	localparam float_t FLOAT_QNAN = 16'h7FC0;
	localparam float_t FLOAT_PINF = 16'h7F80;

	////////////////////////////////////////////////////////////
	// control encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0]
	{
		FPU_IDLE = 3'd0,
		FPU_ADD  = 3'd1,
		FPU_SUB  = 3'd2,
		FPU_EQ   = 3'd3,
		FPU_LT   = 3'd4,
		FPU_LE   = 3'd5
	} fpu_opcode_e;

	typedef enum logic
	{
		FPU_RND_NEAREST = 1'b0,
		FPU_RND_TRUNC   = 1'b1
	} fpu_rnd_mode_e;

	typedef enum logic [1:0]
	{
		FPU_S_IDLE = 2'd0,
		FPU_S_WORK = 2'd1,
		FPU_S_DONE = 2'd2
	} fpu_state_e;

	////////////////////////////////////////////////////////////
	// datapath records
	////////////////////////////////////////////////////////////

	// unpacked operand, subnormals carry exponent 1 and hidden bit 0
	typedef struct packed
	{
		logic      sign;
		ext_exp_t  exp;
		ext_frac_t frac;
		logic      is_zero;
		logic      is_inf;
		logic      is_snan;
		logic      is_qnan;
	} fpu_operand_t;

	// result before rounding; special_val is final when is_special is set
	typedef struct packed
	{
		logic      sign;
		ext_exp_t  exp;
		rnd_frac_t frac;
		logic      is_special;
		logic      is_overflow;
		float_t    special_val;
	} fpu_prernd_t;

	function automatic fpu_operand_t split_operand(float_t w);
		fpu_operand_t op;
		exp_t e;
		logic [FLOAT_F_DW-1:0] f;
		logic e_zero;
		logic e_ones;
		e = w[FLOAT_DW-2 -: FLOAT_E_DW];
		f = w[FLOAT_F_DW-1:0];
		e_zero = (e == '0);
		e_ones = &e;
		op.sign    = w[FLOAT_DW-1];
		op.exp     = e_zero ? ext_exp_t'(1) : {1'b0, e};
		op.frac    = {~e_zero, f};
		op.is_zero = e_zero && (f == '0);
		op.is_inf  = e_ones && (f == '0);
		op.is_snan = e_ones && (f != '0) && !f[FLOAT_F_DW-1];
		op.is_qnan = e_ones && f[FLOAT_F_DW-1];
		return op;
	endfunction

	// magnitude only, sign ignored
	function automatic logic op1_gt_op2(fpu_operand_t a, fpu_operand_t b);
		return {a.exp, a.frac} > {b.exp, b.frac};
	endfunction

endpackage

// File: logic/fpu_operand_unpack.sv
`timescale 1ns/1ps
// operand front end of the FPU
// classifies both operands and registers them with their magnitude order
module fpu_operand_unpack (
	input  logic                  clk,
	input  logic                  rst,
	input  fpu_pkg::float_t       op1_i,
	input  fpu_pkg::float_t       op2_i,
	output fpu_pkg::fpu_operand_t opa_o,
	output fpu_pkg::fpu_operand_t opb_o,
	output logic                  op1_gt_op2_o,
	output fpu_pkg::ext_exp_t     e_diff_o
);

	fpu_pkg::fpu_operand_t opa_next;
	fpu_pkg::fpu_operand_t opb_next;
	logic                  gt_next;
	fpu_pkg::ext_exp_t     e_diff_next;

	////////////////////////////////////////////////////////////
	// classification
	////////////////////////////////////////////////////////////

	always_comb
	begin
		opa_next = fpu_pkg::split_operand(op1_i);
		opb_next = fpu_pkg::split_operand(op2_i);
		gt_next  = fpu_pkg::op1_gt_op2(opa_next, opb_next);
		// always non-negative, larger minus smaller
		if (gt_next)
		begin
			e_diff_next = opa_next.exp - opb_next.exp;
		end
		else
		begin
			e_diff_next = opb_next.exp - opa_next.exp;
		end
	end

	////////////////////////////////////////////////////////////
	// registers, loaded every cycle
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			opa_o        <= '0;
			opb_o        <= '0;
			op1_gt_op2_o <= 1'b0;
			e_diff_o     <= '0;
		end
		else
		begin
			opa_o        <= opa_next;
			opb_o        <= opb_next;
			op1_gt_op2_o <= gt_next;
			e_diff_o     <= e_diff_next;
		end
	end

endmodule

// File: logic/fpu_addsub.sv
`timescale 1ns/1ps
// two-stage bfloat16 add/subtract that leaves the result unrounded for fpu_round
// stage 1 aligns the operands and stage 2 adds and normalizes
module fpu_addsub (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start_i,
	input  logic                  is_sub_i,
	input  fpu_pkg::fpu_operand_t opa_i,
	input  fpu_pkg::fpu_operand_t opb_i,
	input  logic                  op1_gt_op2_i,
	input  fpu_pkg::ext_exp_t     e_diff_i,
	output fpu_pkg::fpu_prernd_t  res_o,
	output logic                  valid_o
);

	// stage 1 combinational
	logic              b_sign;
	logic              a_nan;
	logic              b_nan;
	logic              small_sign;
	fpu_pkg::ext_exp_t align_sh;
	logic [21:0]       align_wide;
	fpu_pkg::ext_frac_t small_frac;

	// stage 1 registers
	logic              s1_valid;
	logic              s1_sign;
	logic              s1_eff_sub;
	fpu_pkg::ext_exp_t s1_exp;
	fpu_pkg::rnd_frac_t s1_big;
	fpu_pkg::rnd_frac_t s1_small;
	logic              s1_special;
	fpu_pkg::float_t   s1_special_val;

	// stage 2 combinational
	logic [11:0]          sum;
	logic [3:0]           lz;
	fpu_pkg::ext_exp_t    norm_limit;
	fpu_pkg::ext_exp_t    norm_sh;
	fpu_pkg::fpu_prernd_t res_next;

	////////////////////////////////////////////////////////////
	// stage 1 alignment and special operands
	////////////////////////////////////////////////////////////

	always_comb
	begin
		b_sign     = opb_i.sign ^ is_sub_i;
		a_nan      = opa_i.is_snan | opa_i.is_qnan;
		b_nan      = opb_i.is_snan | opb_i.is_qnan;
		small_sign = op1_gt_op2_i ? b_sign : opa_i.sign;
		small_frac = op1_gt_op2_i ? opb_i.frac : opa_i.frac;
		// from 14 on the whole smaller fraction sits in sticky
		align_sh   = (e_diff_i > 9'd14) ? 9'd14 : e_diff_i;
		align_wide = {small_frac, 14'b0} >> align_sh;
	end

	always_ff @(posedge clk)
	begin
		s1_sign    <= op1_gt_op2_i ? opa_i.sign : b_sign;
		s1_exp     <= op1_gt_op2_i ? opa_i.exp : opb_i.exp;
		s1_big     <= {(op1_gt_op2_i ? opa_i.frac : opb_i.frac), 3'b000};
		s1_small   <= {align_wide[21:12], |align_wide[11:0]};
		s1_eff_sub <= (op1_gt_op2_i ? opa_i.sign : b_sign) ^ small_sign;
		s1_special <= a_nan | b_nan | opa_i.is_inf | opb_i.is_inf;
		if (a_nan || b_nan)
		begin
			s1_special_val <= fpu_pkg::FLOAT_QNAN;
		end
		else if (opa_i.is_inf && opb_i.is_inf && (opa_i.sign != b_sign))
		begin
			s1_special_val <= fpu_pkg::FLOAT_QNAN;
		end
		else if (opa_i.is_inf)
		begin
			s1_special_val <= {opa_i.sign, fpu_pkg::FLOAT_PINF[14:0]};
		end
		else
		begin
			s1_special_val <= {b_sign, fpu_pkg::FLOAT_PINF[14:0]};
		end
	end

	////////////////////////////////////////////////////////////
	// stage 2 magnitude add and normalization
	////////////////////////////////////////////////////////////

	always_comb
	begin
		// big is never smaller than small so the difference stays non-negative
		if (s1_eff_sub)
		begin
			sum = {1'b0, s1_big} - {1'b0, s1_small};
		end
		else
		begin
			sum = {1'b0, s1_big} + {1'b0, s1_small};
		end
		lz = 4'd11;
		for (int i = 0; i < 11; i++)
		begin
			if (sum[i])
			begin
				lz = 4'(10 - i);
			end
		end
		norm_limit = s1_exp - 9'd1;
		norm_sh    = ({5'b0, lz} > norm_limit) ? norm_limit : {5'b0, lz};

		res_next             = '0;
		res_next.sign        = s1_sign;
		res_next.is_special  = s1_special;
		res_next.special_val = s1_special_val;
		if (sum == '0)
		begin
			// exact cancellation is +0
			res_next.sign = s1_sign & ~s1_eff_sub;
			res_next.exp  = 9'd1;
			res_next.frac = '0;
		end
		else if (sum[11])
		begin
			res_next.exp  = s1_exp + 9'd1;
			res_next.frac = {sum[11:2], |sum[1:0]};
		end
		else
		begin
			// stop at exponent 1 and leave a subnormal
			res_next.exp  = s1_exp - norm_sh;
			res_next.frac = sum[10:0] << norm_sh;
		end
		res_next.is_overflow = (res_next.exp >= 9'd255);
	end

	always_ff @(posedge clk)
	begin
		res_o <= res_next;
	end

	// handshake of both stages
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s1_valid <= 1'b0;
			valid_o  <= 1'b0;
		end
		else
		begin
			s1_valid <= start_i;
			valid_o  <= s1_valid;
		end
	end

	// each item leaves the pipe exactly two cycles after entering
	a_two_stage_latency: assert property (@(posedge clk) disable iff (rst)
		valid_o == $past(start_i, 2));

endmodule

// File: logic/fpu_cmp.sv
`timescale 1ns/1ps
// IEEE compare unit: equal, less-than, less-or-equal
// one cycle from start to a registered result
module fpu_cmp (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start_i,
	input  fpu_pkg::fpu_opcode_e  opcode_i,
	input  fpu_pkg::fpu_operand_t opa_i,
	input  fpu_pkg::fpu_operand_t opb_i,
	output logic                  cmp_o,
	output logic                  valid_o
);

	logic any_nan;
	logic both_zero;
	logic is_eq;
	logic is_lt;
	logic cmp_next;

	always_comb
	begin
		any_nan   = opa_i.is_snan | opa_i.is_qnan | opb_i.is_snan | opb_i.is_qnan;
		// +0 and -0 are the same value
		both_zero = opa_i.is_zero & opb_i.is_zero;
		is_eq     = !any_nan && (both_zero || (opa_i == opb_i));
		if (any_nan || both_zero)
		begin
			is_lt = 1'b0;
		end
		else if (opa_i.sign != opb_i.sign)
		begin
			is_lt = opa_i.sign;
		end
		else if (opa_i.sign)
		begin
			is_lt = fpu_pkg::op1_gt_op2(opa_i, opb_i);
		end
		else
		begin
			is_lt = fpu_pkg::op1_gt_op2(opb_i, opa_i);
		end
		case (opcode_i)
			fpu_pkg::FPU_EQ: cmp_next = is_eq;
			fpu_pkg::FPU_LT: cmp_next = is_lt;
			fpu_pkg::FPU_LE: cmp_next = is_lt | is_eq;
			default:         cmp_next = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		cmp_o <= cmp_next;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_o <= 1'b0;
		end
		else
		begin
			valid_o <= start_i;
		end
	end

endmodule

// File: logic/fpu_round.sv
`timescale 1ns/1ps
// rounding and packing of an add/sub result into a bfloat16 word
// purely combinational, nearest-even or truncate
module fpu_round (
	input  fpu_pkg::fpu_prernd_t   prernd_i,
	input  fpu_pkg::fpu_rnd_mode_e rnd_mode_i,
	output fpu_pkg::float_t        result_o
);

	logic               lsb;
	logic               inc;
	logic [8:0]         mant_inc;
	fpu_pkg::ext_frac_t mant;
	fpu_pkg::ext_exp_t  exp_r;
	fpu_pkg::exp_t      exp_field;
	logic               ovf;

	always_comb
	begin
		// frac layout: [10:3] mantissa, [2] guard, [1] round, [0] sticky
		lsb      = prernd_i.frac[3];
		inc      = (rnd_mode_i == fpu_pkg::FPU_RND_NEAREST) & prernd_i.frac[2]
			& (prernd_i.frac[1] | prernd_i.frac[0] | lsb);
		mant_inc = {1'b0, prernd_i.frac[10:3]} + 9'(inc);

		// mantissa overflow from rounding bumps the exponent
		if (mant_inc[8])
		begin
			mant  = mant_inc[8:1];
			exp_r = prernd_i.exp + 9'd1;
		end
		else
		begin
			mant  = mant_inc[7:0];
			exp_r = prernd_i.exp;
		end

		ovf = prernd_i.is_overflow | (exp_r >= 9'd255);
		// no hidden bit means subnormal, exponent field 0
		exp_field = mant[7] ? exp_r[7:0] : '0;

		if (prernd_i.is_special)
		begin
			result_o = prernd_i.special_val;
		end
		else if (ovf && (rnd_mode_i == fpu_pkg::FPU_RND_NEAREST))
		begin
			result_o = {prernd_i.sign, fpu_pkg::FLOAT_PINF[14:0]};
		end
		else if (ovf)
		begin
			// largest finite magnitude
			result_o = {prernd_i.sign, 15'(fpu_pkg::FLOAT_PINF[14:0] - 15'd1)};
		end
		else
		begin
			result_o = {prernd_i.sign, exp_field, mant[6:0]};
		end
	end

endmodule

// File: logic/fpu_top.sv
`timescale 1ns/1ps
// bfloat16 FPU for a processor pipeline: control FSM, decode, result registers
// one operation in flight, the result holds until padv_i
module fpu_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   flush_i,
	input  logic                   padv_i,
	input  fpu_pkg::fpu_opcode_e   opcode_i,
	input  fpu_pkg::fpu_rnd_mode_e rnd_mode_i,
	input  fpu_pkg::float_t        op1_i,
	input  fpu_pkg::float_t        op2_i,
	output fpu_pkg::float_t        result_o,
	output logic                   result_valid_o,
	output logic                   ready_o
);

	fpu_pkg::fpu_state_e    state, state_next;
	fpu_pkg::fpu_opcode_e   opcode_r, opcode_next;
	fpu_pkg::fpu_rnd_mode_e rnd_mode_r, rnd_mode_next;
	logic                   addsub_start_r, addsub_start_next;
	logic                   cmp_start_r, cmp_start_next;
	fpu_pkg::float_t        result_next;
	logic                   result_valid_next;

	logic is_addsub_op;
	logic is_cmp_op;
	logic sel_addsub;

	// unit connections
	fpu_pkg::fpu_operand_t opa;
	fpu_pkg::fpu_operand_t opb;
	logic                  op1_gt_op2;
	fpu_pkg::ext_exp_t     e_diff;
	fpu_pkg::fpu_prernd_t  addsub_res;
	logic                  addsub_valid;
	logic                  cmp_res;
	logic                  cmp_valid;
	fpu_pkg::float_t       rnd_res;
	fpu_pkg::float_t       sel_res;
	logic                  sel_valid;

	////////////////////////////////////////////////////////////
	// control FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state          <= fpu_pkg::FPU_S_IDLE;
			opcode_r       <= fpu_pkg::FPU_IDLE;
			rnd_mode_r     <= fpu_pkg::FPU_RND_NEAREST;
			addsub_start_r <= 1'b0;
			cmp_start_r    <= 1'b0;
			result_o       <= '0;
			result_valid_o <= 1'b0;
		end
		else
		begin
			state          <= state_next;
			opcode_r       <= opcode_next;
			rnd_mode_r     <= rnd_mode_next;
			addsub_start_r <= addsub_start_next;
			cmp_start_r    <= cmp_start_next;
			result_o       <= result_next;
			result_valid_o <= result_valid_next;
		end
	end

	always_comb
	begin
		is_addsub_op = (opcode_i == fpu_pkg::FPU_ADD) || (opcode_i == fpu_pkg::FPU_SUB);
		is_cmp_op    = (opcode_i == fpu_pkg::FPU_EQ) || (opcode_i == fpu_pkg::FPU_LT)
			|| (opcode_i == fpu_pkg::FPU_LE);
		sel_addsub   = (opcode_r == fpu_pkg::FPU_ADD) || (opcode_r == fpu_pkg::FPU_SUB);
		// compare result is zero-extended
		sel_res      = sel_addsub ? rnd_res : {15'b0, cmp_res};
		sel_valid    = sel_addsub ? addsub_valid : cmp_valid;

		state_next        = state;
		opcode_next       = opcode_r;
		rnd_mode_next     = rnd_mode_r;
		addsub_start_next = 1'b0;
		cmp_start_next    = 1'b0;
		result_next       = result_o;
		result_valid_next = result_valid_o;

		case (state)
			fpu_pkg::FPU_S_IDLE:
			begin
				// flush only cancels an operation on its accepting edge
				if (!flush_i && (is_addsub_op || is_cmp_op))
				begin
					state_next        = fpu_pkg::FPU_S_WORK;
					opcode_next       = opcode_i;
					rnd_mode_next     = rnd_mode_i;
					addsub_start_next = is_addsub_op;
					cmp_start_next    = is_cmp_op;
				end
			end
			fpu_pkg::FPU_S_WORK:
			begin
				if (sel_valid)
				begin
					result_next       = sel_res;
					result_valid_next = 1'b1;
					state_next        = fpu_pkg::FPU_S_DONE;
				end
			end
			fpu_pkg::FPU_S_DONE:
			begin
				if (padv_i)
				begin
					result_valid_next = 1'b0;
					state_next        = fpu_pkg::FPU_S_IDLE;
				end
			end
			default:
			begin
				state_next = fpu_pkg::FPU_S_IDLE;
			end
		endcase
	end

	assign ready_o = (opcode_i == fpu_pkg::FPU_IDLE) | result_valid_o;

	////////////////////////////////////////////////////////////
	// units
	////////////////////////////////////////////////////////////

	fpu_operand_unpack unpack0 (
		.clk          (clk),
		.rst          (rst),
		.op1_i        (op1_i),
		.op2_i        (op2_i),
		.opa_o        (opa),
		.opb_o        (opb),
		.op1_gt_op2_o (op1_gt_op2),
		.e_diff_o     (e_diff)
	);

	fpu_addsub addsub0 (
		.clk          (clk),
		.rst          (rst),
		.start_i      (addsub_start_r),
		.is_sub_i     (opcode_r == fpu_pkg::FPU_SUB),
		.opa_i        (opa),
		.opb_i        (opb),
		.op1_gt_op2_i (op1_gt_op2),
		.e_diff_i     (e_diff),
		.res_o        (addsub_res),
		.valid_o      (addsub_valid)
	);

	fpu_cmp cmp0 (
		.clk      (clk),
		.rst      (rst),
		.start_i  (cmp_start_r),
		.opcode_i (opcode_r),
		.opa_i    (opa),
		.opb_i    (opb),
		.cmp_o    (cmp_res),
		.valid_o  (cmp_valid)
	);

	fpu_round round0 (
		.prernd_i   (addsub_res),
		.rnd_mode_i (rnd_mode_r),
		.result_o   (rnd_res)
	);

	// held result under back-pressure
	a_done_hold: assert property (@(posedge clk) disable iff (rst)
		(state == fpu_pkg::FPU_S_DONE && !padv_i)
		|=> ($stable(result_o) && $stable(result_valid_o)));

	a_one_start: assert property (@(posedge clk) disable iff (rst)
		$onehot0({addsub_start_r, cmp_start_r}));

endmodule

// File: tests/fpu_vectors.svh
// operands and expected results for the directed FPU tests
// each row holds group, opcode, op1, op2 and the results under nearest-even and truncate
`ifndef FPU_VECTORS_SVH
`define FPU_VECTORS_SVH

localparam fpu_pkg::float_t BF_PZERO = 16'h0000;
localparam fpu_pkg::float_t BF_NZERO = 16'h8000;
localparam fpu_pkg::float_t BF_ONE   = 16'h3F80;
localparam fpu_pkg::float_t BF_MONE  = 16'hBF80;
localparam fpu_pkg::float_t BF_TWO   = 16'h4000;
localparam fpu_pkg::float_t BF_MTWO  = 16'hC000;
localparam fpu_pkg::float_t BF_THREE = 16'h4040;
localparam fpu_pkg::float_t BF_MAXF  = 16'h7F7F;
localparam fpu_pkg::float_t BF_PINF  = 16'h7F80;
localparam fpu_pkg::float_t BF_QNAN  = 16'h7FC0;

localparam logic [1:0] GRP_EXACT   = 2'd0;
localparam logic [1:0] GRP_ROUND   = 2'd1;
localparam logic [1:0] GRP_SPECIAL = 2'd2;
localparam logic [1:0] GRP_CMP     = 2'd3;

typedef struct packed
{
	logic [1:0]           group;
	fpu_pkg::fpu_opcode_e opcode;
	fpu_pkg::float_t      op1;
	fpu_pkg::float_t      op2;
	fpu_pkg::float_t      res_near;
	fpu_pkg::float_t      res_trunc;
} vector_t;

localparam int NUM_VECTORS = 20;

localparam vector_t VECTORS [NUM_VECTORS] = '{
	'{GRP_EXACT, fpu_pkg::FPU_ADD, BF_ONE, BF_TWO, BF_THREE, BF_THREE},
	'{GRP_EXACT, fpu_pkg::FPU_SUB, BF_THREE, BF_ONE, BF_TWO, BF_TWO},
	'{GRP_EXACT, fpu_pkg::FPU_ADD, BF_MTWO, BF_ONE, BF_MONE, BF_MONE},
	'{GRP_EXACT, fpu_pkg::FPU_SUB, BF_THREE, BF_THREE, BF_PZERO, BF_PZERO},
	// tie on the guard bit with lsb set
	'{GRP_ROUND, fpu_pkg::FPU_ADD, 16'h3F81, 16'h3B80, 16'h3F82, 16'h3F81},
	'{GRP_ROUND, fpu_pkg::FPU_ADD, BF_ONE, 16'h3B80, BF_ONE, BF_ONE},
	'{GRP_ROUND, fpu_pkg::FPU_ADD, BF_MAXF, BF_MAXF, BF_PINF, BF_MAXF},
	// subtrahend far below the round bit, seen only through sticky
	'{GRP_ROUND, fpu_pkg::FPU_SUB, BF_ONE, 16'h3380, BF_ONE, 16'h3F7F},
	'{GRP_SPECIAL, fpu_pkg::FPU_SUB, BF_PINF, BF_PINF, BF_QNAN, BF_QNAN},
	'{GRP_SPECIAL, fpu_pkg::FPU_ADD, 16'h7FC1, BF_ONE, BF_QNAN, BF_QNAN},
	'{GRP_SPECIAL, fpu_pkg::FPU_SUB, BF_TWO, 16'h7FC1, BF_QNAN, BF_QNAN},
	'{GRP_SPECIAL, fpu_pkg::FPU_ADD, BF_PINF, BF_ONE, BF_PINF, BF_PINF},
	'{GRP_SPECIAL, fpu_pkg::FPU_ADD, 16'h0001, 16'h0001, 16'h0002, 16'h0002},
	'{GRP_CMP, fpu_pkg::FPU_EQ, BF_PZERO, BF_NZERO, 16'h0001, 16'h0001},
	'{GRP_CMP, fpu_pkg::FPU_LT, BF_MONE, BF_ONE, 16'h0001, 16'h0001},
	'{GRP_CMP, fpu_pkg::FPU_LE, BF_TWO, BF_TWO, 16'h0001, 16'h0001},
	'{GRP_CMP, fpu_pkg::FPU_LT, BF_TWO, BF_ONE, 16'h0000, 16'h0000},
	'{GRP_CMP, fpu_pkg::FPU_EQ, BF_QNAN, BF_QNAN, 16'h0000, 16'h0000},
	'{GRP_CMP, fpu_pkg::FPU_LT, BF_ONE, BF_QNAN, 16'h0000, 16'h0000},
	'{GRP_CMP, fpu_pkg::FPU_LE, BF_QNAN, BF_ONE, 16'h0000, 16'h0000}
};

`endif

// File: tests/fpu_tb.sv
`timescale 1ns/1ps
// directed testbench for the bfloat16 FPU
// covers add/sub, rounding, specials, compares, latency, flush and back-pressure
module fpu_tb;

	`include "fpu_vectors.svh"

	localparam int WAIT_LIMIT = 20;

	logic                   clk;
	logic                   rst;
	logic                   flush;
	logic                   padv;
	fpu_pkg::fpu_opcode_e   opcode;
	fpu_pkg::fpu_rnd_mode_e rnd_mode;
	fpu_pkg::float_t        op1;
	fpu_pkg::float_t        op2;
	fpu_pkg::float_t        result;
	logic                   result_valid;
	logic                   ready;

	fpu_top dut0 (
		.clk            (clk),
		.rst            (rst),
		.flush_i        (flush),
		.padv_i         (padv),
		.opcode_i       (opcode),
		.rnd_mode_i     (rnd_mode),
		.op1_i          (op1),
		.op2_i          (op2),
		.result_o       (result),
		.result_valid_o (result_valid),
		.ready_o        (ready)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////
	// reporting
	////////////////////////////////////////////////////////////

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			abort_run($sformatf("[FAIL] %s: expected %0h, actual %0h", name, expected, actual));
		end
	endtask

	////////////////////////////////////////////////////////////
	// one operation from opcode to padv
	////////////////////////////////////////////////////////////

	task automatic do_op(input string name, input fpu_pkg::fpu_opcode_e op,
		input fpu_pkg::fpu_rnd_mode_e mode, input fpu_pkg::float_t a,
		input fpu_pkg::float_t b, input fpu_pkg::float_t expected, input int hold_cycles);
		int              edges;
		int              exp_latency;
		logic            got_valid;
		fpu_pkg::float_t held;
		// add/sub goes through both pipeline stages, compare through one
		exp_latency = (op == fpu_pkg::FPU_ADD || op == fpu_pkg::FPU_SUB) ? 3 : 2;
		@(posedge clk);
		opcode   <= op;
		rnd_mode <= mode;
		op1      <= a;
		op2      <= b;
		edges     = 0;
		got_valid = 1'b0;
		while (!got_valid && edges < WAIT_LIMIT)
		begin
			@(posedge clk);
			#1;
			edges++;
			got_valid = result_valid;
			if (!got_valid)
			begin
				check_value({name, " ready while busy"}, 0, 32'(ready));
			end
		end
		if (!got_valid)
		begin
			abort_run($sformatf("timeout: %s gave no result within %0d cycles", name, WAIT_LIMIT));
		end
		// first counted edge is the accepting one
		check_value({name, " latency"}, exp_latency, edges - 1);
		check_value({name, " ready with result"}, 1, 32'(ready));
		check_value(name, 32'(expected), 32'(result));
		held = result;

		@(posedge clk);
		opcode <= fpu_pkg::FPU_IDLE;
		for (int i = 0; i < hold_cycles; i++)
		begin
			@(posedge clk);
			#1;
			check_value({name, " valid held"}, 1, 32'(result_valid));
			check_value({name, " result held"}, 32'(held), 32'(result));
		end
		@(posedge clk);
		padv <= 1'b1;
		@(posedge clk);
		padv <= 1'b0;
		#1;
		check_value({name, " valid after padv"}, 0, 32'(result_valid));
	endtask

	// each vector of a group, once per rounding mode
	task automatic run_vectors(input logic [1:0] grp, input string label);
		fpu_pkg::fpu_rnd_mode_e mode;
		fpu_pkg::float_t        expected;
		string                  name;
		for (int i = 0; i < NUM_VECTORS; i++)
		begin
			if (VECTORS[i].group == grp)
			begin
				for (int m = 0; m < 2; m++)
				begin
					mode     = (m == 0) ? fpu_pkg::FPU_RND_NEAREST : fpu_pkg::FPU_RND_TRUNC;
					expected = (m == 0) ? VECTORS[i].res_near : VECTORS[i].res_trunc;
					name     = $sformatf("%s #%0d %s", label, i, (m == 0) ? "nearest" : "trunc");
					do_op(name, VECTORS[i].opcode, mode, VECTORS[i].op1, VECTORS[i].op2,
						expected, 0);
				end
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic exact_addsub();
		run_vectors(GRP_EXACT, "exact");
	endtask

	task automatic rounding_modes();
		run_vectors(GRP_ROUND, "rounding");
	endtask

	task automatic special_values();
		run_vectors(GRP_SPECIAL, "special");
	endtask

	task automatic compares();
		run_vectors(GRP_CMP, "compare");
	endtask

	task automatic latency_and_ready();
		check_value("ready when idle", 1, 32'(ready));
		do_op("latency add", fpu_pkg::FPU_ADD, fpu_pkg::FPU_RND_NEAREST, BF_ONE, BF_TWO,
			BF_THREE, 0);
		do_op("latency compare", fpu_pkg::FPU_LE, fpu_pkg::FPU_RND_NEAREST, BF_ONE, BF_TWO,
			16'h0001, 0);
	endtask

	task automatic flush_cancel();
		@(posedge clk);
		flush  <= 1'b1;
		opcode <= fpu_pkg::FPU_ADD;
		op1    <= BF_ONE;
		op2    <= BF_ONE;
		for (int i = 0; i < 10; i++)
		begin
			@(posedge clk);
			#1;
			check_value("flush gives no result", 0, 32'(result_valid));
		end
		@(posedge clk);
		flush  <= 1'b0;
		opcode <= fpu_pkg::FPU_IDLE;
		// machine must still be idle and accept the next op
		do_op("after flush", fpu_pkg::FPU_ADD, fpu_pkg::FPU_RND_NEAREST, BF_ONE, BF_ONE,
			BF_TWO, 0);
	endtask

	task automatic backpressure_hold();
		do_op("back-pressure", fpu_pkg::FPU_SUB, fpu_pkg::FPU_RND_NEAREST, BF_THREE, BF_ONE,
			BF_TWO, 6);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		clk      = 1'b0;
		rst      = 1'b1;
		flush    = 1'b0;
		padv     = 1'b0;
		opcode   = fpu_pkg::FPU_IDLE;
		rnd_mode = fpu_pkg::FPU_RND_NEAREST;
		op1      = '0;
		op2      = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		#1;
		check_value("reset valid", 0, 32'(result_valid));
		check_value("reset result", 0, 32'(result));

		exact_addsub();
		rounding_modes();
		special_values();
		compares();
		latency_and_ready();
		flush_cancel();
		backpressure_hold();

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+tests
logic/fpu_pkg.sv
logic/fpu_operand_unpack.sv
logic/fpu_addsub.sv
logic/fpu_cmp.sv
logic/fpu_round.sv
logic/fpu_top.sv
tests/fpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the FPU testbench with Verilator, run it, and check the output for a pass
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
	--top-module fpu_tb -o fpu_sim || { echo "run_sim: build failed"; exit 1; }

sim_out="$(./obj_dir/fpu_sim 2>&1)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "SIMULATION PASSED" && echo "run_sim: ok" \
	|| { echo "run_sim: simulation did not pass"; exit 1; }
